/* mci_pkg.sv */
// MCI subordinate fabric shared definitions
// Memory map, request and response structs, strap and privilege
// bundles, and the target, mailbox and register encodings
package mci_pkg;

    ////////////////////
    // Widths
    ////////////////////
    localparam int unsigned DATA_W     = 32;
    localparam int unsigned USER_W     = 32;
    localparam int unsigned ADDR_W     = 32;
    // Upper address bits are ignored by the decode
    localparam int unsigned INT_ADDR_W = 24;

    ////////////////////
    // Memory map
    ////////////////////
    localparam logic [INT_ADDR_W-1:0] REG_START   = 24'h00_0000;
    localparam logic [INT_ADDR_W-1:0] REG_END     = 24'h00_0FFF;
    localparam logic [INT_ADDR_W-1:0] MBOX0_START = 24'h40_0000;
    localparam logic [INT_ADDR_W-1:0] MBOX0_END   = 24'h40_007F;
    localparam logic [INT_ADDR_W-1:0] MBOX1_START = 24'h80_0000;
    localparam logic [INT_ADDR_W-1:0] MBOX1_END   = 24'h80_007F;
    localparam logic [INT_ADDR_W-1:0] SRAM_START  = 24'hC0_0000;
    localparam logic [INT_ADDR_W-1:0] SRAM_END    = 24'hC0_0FFF;

    // Storage sizes
    localparam int unsigned SRAM_WORDS = 1024;
    localparam int unsigned SRAM_IDX_W = $clog2(SRAM_WORDS);
    localparam int unsigned MBOX_WORDS = 16;
    localparam int unsigned MBOX_IDX_W = $clog2(MBOX_WORDS);

    // Offset widths inside the register and mailbox windows
    localparam int unsigned REG_OFF_W  = 12;
    localparam int unsigned MBOX_OFF_W = 7;

    // Read-only identification value
    localparam logic [DATA_W-1:0] MCI_ID_VALUE = 32'h4D43_4901;

    ////////////////////
    // Bus structs
    ////////////////////
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic              write;
        logic [USER_W-1:0] user;
    } cif_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              hold;
        logic              error;
    } cif_resp_t;

    // Privileged user straps
    typedef struct packed {
        logic [USER_W-1:0] mcu_lsu_user;
        logic [USER_W-1:0] mcu_ifu_user;
        logic [USER_W-1:0] sram_config_user;
        logic [USER_W-1:0] soc_config_user;
    } mci_strap_t;

    // Per-request privilege flags
    typedef struct packed {
        logic mcu_lsu;
        logic mcu_ifu;
        logic mcu;
        logic soc_config;
        logic sram_config;
    } mci_priv_t;

    ////////////////////
    // Encodings
    ////////////////////
    typedef enum logic [2:0] {
        TGT_NONE,
        TGT_REG,
        TGT_MBOX0,
        TGT_MBOX1,
        TGT_SRAM
    } mci_target_e;

    typedef enum logic {
        MBOX_IDLE,
        MBOX_LOCKED
    } mbox_state_e;

    typedef enum logic [REG_OFF_W-1:0] {
        REG_ID         = 12'h000,
        REG_SCRATCH    = 12'h004,
        REG_SOC_CONFIG = 12'h008
    } mci_reg_addr_e;

    typedef enum logic [MBOX_OFF_W-1:0] {
        MBOX_LOCK       = 7'h00,
        MBOX_STATUS     = 7'h04,
        MBOX_RELEASE    = 7'h08,
        MBOX_DATA_START = 7'h40,
        MBOX_DATA_END   = 7'h7F
    } mbox_reg_addr_e;

endpackage

/* mci_axi_sub_decode.sv */
// MCI subordinate address decoder
// Routes the SoC request to one target, returns that target's
// response or a miss error, and flags privileged requesters
`timescale 1ns/10ps

module mci_axi_sub_decode (
    // SoC side
    input  logic                  soc_dv,
    input  mci_pkg::cif_req_t     soc_req,
    output mci_pkg::cif_resp_t    soc_resp,

    // Target request side
    output logic                  reg_dv,
    output logic                  mbox0_dv,
    output logic                  mbox1_dv,
    output logic                  sram_dv,
    output mci_pkg::cif_req_t     tgt_req,

    // Target responses
    input  mci_pkg::cif_resp_t    reg_resp,
    input  mci_pkg::cif_resp_t    mbox0_resp,
    input  mci_pkg::cif_resp_t    mbox1_resp,
    input  mci_pkg::cif_resp_t    sram_resp,

    // Privileged users
    input  mci_pkg::mci_strap_t   strap,
    output mci_pkg::mci_priv_t    priv
);

    logic [mci_pkg::INT_ADDR_W-1:0] int_addr;
    mci_pkg::mci_target_e           tgt;
    logic                           soc_req_miss;

    logic soc_cfg_disable;
    logic soc_cfg_force;
    logic soc_cfg_match;

    ////////////////////
    // Address decode
    ////////////////////
    // Only the low internal bits take part
    assign int_addr = soc_req.addr[mci_pkg::INT_ADDR_W-1:0];

    always_comb begin
        tgt = mci_pkg::TGT_NONE;
        if (soc_dv) begin
            if (int_addr inside {[mci_pkg::REG_START:mci_pkg::REG_END]}) begin
                tgt = mci_pkg::TGT_REG;
            end else if (int_addr inside {[mci_pkg::MBOX0_START:mci_pkg::MBOX0_END]}) begin
                tgt = mci_pkg::TGT_MBOX0;
            end else if (int_addr inside {[mci_pkg::MBOX1_START:mci_pkg::MBOX1_END]}) begin
                tgt = mci_pkg::TGT_MBOX1;
            end else if (int_addr inside {[mci_pkg::SRAM_START:mci_pkg::SRAM_END]}) begin
                tgt = mci_pkg::TGT_SRAM;
            end
        end
    end

    // Request valid to the selected target only
    assign reg_dv   = (tgt == mci_pkg::TGT_REG);
    assign mbox0_dv = (tgt == mci_pkg::TGT_MBOX0);
    assign mbox1_dv = (tgt == mci_pkg::TGT_MBOX1);
    assign sram_dv  = (tgt == mci_pkg::TGT_SRAM);

    // Same request fields to every target
    assign tgt_req = soc_req;

    ////////////////////
    // Response merge
    ////////////////////
    // Valid request that hit no region
    assign soc_req_miss = soc_dv & (tgt == mci_pkg::TGT_NONE);

    always_comb begin
        case (tgt)
            mci_pkg::TGT_REG:   soc_resp = reg_resp;
            mci_pkg::TGT_MBOX0: soc_resp = mbox0_resp;
            mci_pkg::TGT_MBOX1: soc_resp = mbox1_resp;
            mci_pkg::TGT_SRAM:  soc_resp = sram_resp;
            default: begin
                // Miss answers at once with zero data
                soc_resp.rdata = '0;
                soc_resp.hold  = 1'b0;
                soc_resp.error = soc_req_miss;
            end
        endcase
    end

    ////////////////////
    // Privilege flags
    ////////////////////
    // All zeros turns the SoC config user off
    assign soc_cfg_disable = ~|strap.soc_config_user;
    // All ones makes every request a SoC config request
    assign soc_cfg_force   = &strap.soc_config_user;
    assign soc_cfg_match   = (soc_req.user == strap.soc_config_user);

    always_comb begin
        priv.mcu_lsu     = soc_dv & (soc_req.user == strap.mcu_lsu_user);
        priv.mcu_ifu     = soc_dv & (soc_req.user == strap.mcu_ifu_user);
        // Either MCU port counts as the MCU
        priv.mcu         = priv.mcu_lsu | priv.mcu_ifu;
        priv.soc_config  = soc_dv & ((soc_cfg_match & ~soc_cfg_disable) | soc_cfg_force);
        priv.sram_config = soc_dv & (soc_req.user == strap.sram_config_user);
    end

endmodule

/* mci_reg_block.sv */
// MCI control register block
// ID, scratch and a SoC config register that only the
// privileged SoC config user may write
`timescale 1ns/10ps

module mci_reg_block (
    input  logic                clk,
    input  logic                rst,
    input  logic                dv,
    input  mci_pkg::cif_req_t   req,
    input  logic                soc_config_priv,
    output mci_pkg::cif_resp_t  resp
);

    logic [mci_pkg::DATA_W-1:0] scratch_q;
    logic [mci_pkg::DATA_W-1:0] soc_config_q;
    mci_pkg::mci_reg_addr_e     reg_off;
    logic                       wr_scratch;
    logic                       wr_soc_config;

    // Word offset inside the register window
    assign reg_off = mci_pkg::mci_reg_addr_e'(req.addr[mci_pkg::REG_OFF_W-1:0]);

    ////////////////////
    // Read and write decode
    ////////////////////
    always_comb begin
        resp          = '0;
        wr_scratch    = 1'b0;
        wr_soc_config = 1'b0;
        case (reg_off)
            mci_pkg::REG_ID: begin
                resp.rdata = mci_pkg::MCI_ID_VALUE;
                // Read only
                resp.error = dv & req.write;
            end
            mci_pkg::REG_SCRATCH: begin
                resp.rdata = scratch_q;
                wr_scratch = dv & req.write;
            end
            mci_pkg::REG_SOC_CONFIG: begin
                resp.rdata    = soc_config_q;
                wr_soc_config = dv & req.write & soc_config_priv;
                // Unprivileged write is refused
                resp.error    = dv & req.write & ~soc_config_priv;
            end
            default: begin
                resp.error = dv;
            end
        endcase
    end

    // Register updates
    always_ff @(posedge clk) begin
        if (rst) begin
            scratch_q    <= '0;
            soc_config_q <= '0;
        end else begin
            if (wr_scratch) begin
                scratch_q <= req.wdata;
            end
            if (wr_soc_config) begin
                soc_config_q <= req.wdata;
            end
        end
    end

endmodule

/* mci_mbox.sv */
// MCI mailbox
// Lock semaphore taken by reading LOCK, freed by writing RELEASE,
// and a small data buffer writable only while locked
`timescale 1ns/10ps

module mci_mbox (
    input  logic                clk,
    input  logic                rst,
    input  logic                dv,
    input  mci_pkg::cif_req_t   req,
    output mci_pkg::cif_resp_t  resp
);

    mci_pkg::mbox_state_e       state_q;
    mci_pkg::mbox_state_e       state_d;
    mci_pkg::mbox_reg_addr_e    mbox_off;
    logic                       locked;
    logic                       in_data;
    logic                       data_we;
    logic [mci_pkg::MBOX_IDX_W-1:0] data_idx;

    // Data buffer has no reset
    logic [mci_pkg::DATA_W-1:0] data_q [mci_pkg::MBOX_WORDS];

    assign mbox_off = mci_pkg::mbox_reg_addr_e'(req.addr[mci_pkg::MBOX_OFF_W-1:0]);
    assign locked   = (state_q == mci_pkg::MBOX_LOCKED);
    assign in_data  = mbox_off inside {[mci_pkg::MBOX_DATA_START:mci_pkg::MBOX_DATA_END]};
    assign data_idx = req.addr[mci_pkg::MBOX_IDX_W+1:2];

    ////////////////////
    // Access decode
    ////////////////////
    always_comb begin
        resp    = '0;
        state_d = state_q;
        data_we = 1'b0;
        if (in_data) begin
            resp.rdata = data_q[data_idx];
            data_we    = dv & req.write & locked;
            // Buffer is closed while idle
            resp.error = dv & req.write & ~locked;
        end else begin
            case (mbox_off)
                mci_pkg::MBOX_LOCK: begin
                    // Old lock state comes back, then the lock is held
                    resp.rdata = mci_pkg::DATA_W'(locked);
                    resp.error = dv & req.write;
                    if (dv & ~req.write) begin
                        state_d = mci_pkg::MBOX_LOCKED;
                    end
                end
                mci_pkg::MBOX_STATUS: begin
                    resp.rdata = mci_pkg::DATA_W'(locked);
                    resp.error = dv & req.write;
                end
                mci_pkg::MBOX_RELEASE: begin
                    if (dv & req.write) begin
                        state_d = mci_pkg::MBOX_IDLE;
                    end
                end
                default: begin
                    resp.error = dv;
                end
            endcase
        end
    end

    // Lock state
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= mci_pkg::MBOX_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Buffer writes
    always_ff @(posedge clk) begin
        if (data_we) begin
            data_q[data_idx] <= req.wdata;
        end
    end

endmodule

/* mci_sram.sv */
// MCU SRAM target
// Synchronous read with one wait cycle, writes only from
// privileged users
`timescale 1ns/10ps

module mci_sram (
    input  logic                clk,
    input  logic                rst,
    input  logic                dv,
    input  mci_pkg::cif_req_t   req,
    input  logic                write_priv,
    output mci_pkg::cif_resp_t  resp
);

    logic [mci_pkg::DATA_W-1:0]     mem [mci_pkg::SRAM_WORDS];
    logic [mci_pkg::SRAM_IDX_W-1:0] idx;
    logic [mci_pkg::DATA_W-1:0]     rdata_q;
    logic                           rd_pend_q;
    logic                           rd_first;
    logic                           wr_en;

    // Word index from the byte address
    assign idx      = req.addr[mci_pkg::SRAM_IDX_W+1:2];
    // First cycle of a read, before the word is fetched
    assign rd_first = dv & ~req.write & ~rd_pend_q;
    assign wr_en    = dv & req.write & write_priv;

    // Hold on the first read cycle only
    assign resp.hold  = rd_first;
    assign resp.rdata = rdata_q;
    assign resp.error = dv & req.write & ~write_priv;

    // Read pending flag
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pend_q <= 1'b0;
        end else begin
            rd_pend_q <= rd_first;
        end
    end

    // Memory array and registered read word
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[idx] <= req.wdata;
        end
        if (rd_first) begin
            rdata_q <= mem[idx];
        end
    end

endmodule

/* mci_sub_top.sv */
// MCI SoC subordinate fabric top
// Decoder feeding the register block, two mailboxes and the MCU SRAM
`timescale 1ns/10ps

module mci_sub_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 soc_dv,
    input  mci_pkg::cif_req_t    soc_req,
    output mci_pkg::cif_resp_t   soc_resp,
    input  mci_pkg::mci_strap_t  strap,
    output mci_pkg::mci_priv_t   priv
);

    ////////////////////
    // Fabric wires
    ////////////////////
    logic                reg_dv;
    logic                mbox0_dv;
    logic                mbox1_dv;
    logic                sram_dv;
    mci_pkg::cif_req_t   tgt_req;
    mci_pkg::cif_resp_t  reg_resp;
    mci_pkg::cif_resp_t  mbox0_resp;
    mci_pkg::cif_resp_t  mbox1_resp;
    mci_pkg::cif_resp_t  sram_resp;

    // Address decode and privilege detect
    mci_axi_sub_decode u_decode (
        .soc_dv     (soc_dv),
        .soc_req    (soc_req),
        .soc_resp   (soc_resp),
        .reg_dv     (reg_dv),
        .mbox0_dv   (mbox0_dv),
        .mbox1_dv   (mbox1_dv),
        .sram_dv    (sram_dv),
        .tgt_req    (tgt_req),
        .reg_resp   (reg_resp),
        .mbox0_resp (mbox0_resp),
        .mbox1_resp (mbox1_resp),
        .sram_resp  (sram_resp),
        .strap      (strap),
        .priv       (priv)
    );

    // Control registers
    mci_reg_block u_reg (
        .clk             (clk),
        .rst             (rst),
        .dv              (reg_dv),
        .req             (tgt_req),
        .soc_config_priv (priv.soc_config),
        .resp            (reg_resp)
    );

    // Mailboxes
    mci_mbox u_mbox0 (
        .clk  (clk),
        .rst  (rst),
        .dv   (mbox0_dv),
        .req  (tgt_req),
        .resp (mbox0_resp)
    );

    mci_mbox u_mbox1 (
        .clk  (clk),
        .rst  (rst),
        .dv   (mbox1_dv),
        .req  (tgt_req),
        .resp (mbox1_resp)
    );

    // MCU SRAM, writable by the MCU or the SRAM config user
    mci_sram u_sram (
        .clk        (clk),
        .rst        (rst),
        .dv         (sram_dv),
        .req        (tgt_req),
        .write_priv (priv.mcu | priv.sram_config),
        .resp       (sram_resp)
    );

endmodule

/* tb_mci_sub.sv */
// MCI subordinate fabric testbench
// Table of SoC requests applied in a loop, each checked for response
// and privilege flags against expected values from the memory map rules
`timescale 1ns/10ps

module tb_mci_sub;

    localparam int CLK_HALF     = 10;
    localparam int SAMPLE_DLY   = 5;
    localparam int HOLD_TIMEOUT = 10;
    localparam int SEED         = 80;

    // Strap users and test users
    localparam logic [31:0] U_LSU   = 32'h0000_0011;
    localparam logic [31:0] U_IFU   = 32'h0000_0022;
    localparam logic [31:0] U_SRAM  = 32'h0000_0033;
    localparam logic [31:0] U_SOC   = 32'h0000_0044;
    localparam logic [31:0] U_NONE  = 32'h0000_0055;
    localparam logic [31:0] U_ZERO  = 32'h0000_0000;
    localparam logic [31:0] CFG_DEF = 32'h0000_0044;
    localparam logic [31:0] CFG_ALL = 32'hFFFF_FFFF;
    localparam logic [31:0] ID_EXP  = 32'h4D43_4901;

    // One request and its expected outcome
    typedef struct packed {
        logic [31:0]        addr;
        logic               write;
        logic [31:0]        wdata;
        logic [31:0]        user;
        logic [31:0]        cfg_strap;
        logic [31:0]        exp_rdata;
        logic               exp_error;
        mci_pkg::mci_priv_t exp_priv;
    } stim_row_t;

    logic                clk;
    logic                rst;
    logic                soc_dv;
    mci_pkg::cif_req_t   soc_req;
    mci_pkg::cif_resp_t  soc_resp;
    mci_pkg::mci_strap_t strap;
    mci_pkg::mci_priv_t  priv;

    stim_row_t           rows [$];
    logic [31:0]         rnd [4];
    mci_pkg::mci_priv_t  p_none;
    mci_pkg::mci_priv_t  p_lsu;
    mci_pkg::mci_priv_t  p_ifu;
    mci_pkg::mci_priv_t  p_soc;
    mci_pkg::mci_priv_t  p_sram;
    mci_pkg::mci_priv_t  p_lsu_soc;

    mci_sub_top dut0 (
        .clk      (clk),
        .rst      (rst),
        .soc_dv   (soc_dv),
        .soc_req  (soc_req),
        .soc_resp (soc_resp),
        .strap    (strap),
        .priv     (priv)
    );

    // 20 ns clock
    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    ////////////////////
    // Helpers
    ////////////////////
    // Prints the reason, then the fail line, then stops
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    function automatic mci_pkg::mci_priv_t priv_flags(input logic lsu, input logic ifu,
                                                      input logic mcu, input logic soc,
                                                      input logic sram);
        mci_pkg::mci_priv_t p;
        p.mcu_lsu     = lsu;
        p.mcu_ifu     = ifu;
        p.mcu         = mcu;
        p.soc_config  = soc;
        p.sram_config = sram;
        return p;
    endfunction

    task automatic add_row(input logic [31:0] addr, input logic write, input logic [31:0] wdata,
                           input logic [31:0] user, input logic [31:0] cfg,
                           input logic [31:0] exp_rdata, input logic exp_error,
                           input mci_pkg::mci_priv_t exp_priv);
        stim_row_t r;
        r.addr      = addr;
        r.write     = write;
        r.wdata     = wdata;
        r.user      = user;
        r.cfg_strap = cfg;
        r.exp_rdata = exp_rdata;
        r.exp_error = exp_error;
        r.exp_priv  = exp_priv;
        rows.push_back(r);
    endtask

    task automatic check_resp(input mci_pkg::cif_resp_t got, input mci_pkg::cif_resp_t exp,
                              input bit chk_rdata, input int idx);
        if (got.hold !== exp.hold || got.error !== exp.error
            || (chk_rdata && got.rdata !== exp.rdata)) begin
            abort_run($sformatf(
                "[FAIL] %0d ns: row %0d resp hold/error/rdata %0b/%0b/%h, exp %0b/%0b/%h",
                $time, idx, got.hold, got.error, got.rdata, exp.hold, exp.error, exp.rdata));
        end
    endtask

    task automatic check_priv(input mci_pkg::mci_priv_t got, input mci_pkg::mci_priv_t exp,
                              input int idx);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0d ns: row %0d priv flags %b, expected %b",
                                $time, idx, got, exp));
        end
    endtask

    // Cycles spent with hold high before the completing cycle
    task automatic check_wait(input int got, input int exp, input int idx);
        if (got != exp) begin
            abort_run($sformatf("[FAIL] %0d ns: row %0d hold lasted %0d cycles, expected %0d",
                                $time, idx, got, exp));
        end
    endtask

    ////////////////////
    // Request driver
    ////////////////////
    // Drive on the falling edge, sample mid low phase until hold drops
    task automatic run_row(input int idx, input stim_row_t r);
        mci_pkg::cif_resp_t exp;
        int                 waited;
        int                 exp_wait;
        @(negedge clk);
        strap.soc_config_user = r.cfg_strap;
        soc_dv        = 1'b1;
        soc_req.addr  = r.addr;
        soc_req.write = r.write;
        soc_req.wdata = r.wdata;
        soc_req.user  = r.user;
        waited        = 0;
        // Only an SRAM read waits, and for exactly one cycle
        exp_wait = (!r.write && r.addr[23:0] >= mci_pkg::SRAM_START
                    && r.addr[23:0] <= mci_pkg::SRAM_END) ? 1 : 0;
        #(SAMPLE_DLY);
        while (soc_resp.hold) begin
            if (waited >= HOLD_TIMEOUT) begin
                abort_run($sformatf("Timeout: hold stayed high for %0d cycles on row %0d, addr %h",
                                    waited, idx, r.addr));
            end else begin
                @(negedge clk);
                #(SAMPLE_DLY);
                waited++;
            end
        end
        check_wait(waited, exp_wait, idx);
        exp.rdata = r.exp_rdata;
        exp.hold  = 1'b0;
        exp.error = r.exp_error;
        // Read data only matters on reads
        check_resp(soc_resp, exp, !r.write, idx);
        check_priv(priv, r.exp_priv, idx);
    endtask

    ////////////////////
    // Stimulus table
    ////////////////////
    task automatic build_table();
        // Decode, scratch, miss, upper bits ignored
        add_row(32'h0000_0000, 1'b0, 32'h0, U_NONE, CFG_DEF, ID_EXP, 1'b0, p_none);
        add_row(32'h0000_0000, 1'b1, 32'h1234_5678, U_NONE, CFG_DEF, 32'h0, 1'b1, p_none);
        add_row(32'h0000_0004, 1'b1, 32'hA5A5_1234, U_NONE, CFG_DEF, 32'h0, 1'b0, p_none);
        add_row(32'h0000_0004, 1'b0, 32'h0, U_NONE, CFG_DEF, 32'hA5A5_1234, 1'b0, p_none);
        add_row(32'h0010_0000, 1'b0, 32'h0, U_NONE, CFG_DEF, 32'h0, 1'b1, p_none);
        add_row(32'h0010_0004, 1'b1, 32'hDEAD_BEEF, U_NONE, CFG_DEF, 32'h0, 1'b1, p_none);
        add_row(32'hFF00_0000, 1'b0, 32'h0, U_NONE, CFG_DEF, ID_EXP, 1'b0, p_none);
        add_row(32'h0000_000C, 1'b0, 32'h0, U_NONE, CFG_DEF, 32'h0, 1'b1, p_none);
        // Privilege flags by user
        add_row(32'h0000_0004, 1'b0, 32'h0, U_LSU, CFG_DEF, 32'hA5A5_1234, 1'b0, p_lsu);
        add_row(32'h0000_0004, 1'b0, 32'h0, U_IFU, CFG_DEF, 32'hA5A5_1234, 1'b0, p_ifu);
        add_row(32'h0000_0004, 1'b0, 32'h0, U_SOC, CFG_DEF, 32'hA5A5_1234, 1'b0, p_soc);
        // Protected SoC config register
        add_row(32'h0000_0008, 1'b1, 32'hC0FF_EE01, U_SOC, CFG_DEF, 32'h0, 1'b0, p_soc);
        add_row(32'h0000_0008, 1'b0, 32'h0, U_NONE, CFG_DEF, 32'hC0FF_EE01, 1'b0, p_none);
        add_row(32'h0000_0008, 1'b1, 32'h1111_2222, U_NONE, CFG_DEF, 32'h0, 1'b1, p_none);
        add_row(32'h0000_0008, 1'b0, 32'h0, U_NONE, CFG_DEF, 32'hC0FF_EE01, 1'b0, p_none);
        // Mailbox 0 lock, data, release
        add_row(32'h0040_0000, 1'b0, 32'h0, U_NONE, CFG_DEF, 32'h0, 1'b0, p_none);
        add_row(32'h0040_0000, 1'b0, 32'h0, U_NONE, CFG_DEF, 32'h1, 1'b0, p_none);
        add_row(32'h0040_0004, 1'b0, 32'h0, U_NONE, CFG_DEF, 32'h1, 1'b0, p_none);
        add_row(32'h0040_0040, 1'b1, 32'h0BAD_F00D, U_NONE, CFG_DEF, 32'h0, 1'b0, p_none);
        add_row(32'h0040_0040, 1'b0, 32'h0, U_NONE, CFG_DEF, 32'h0BAD_F00D, 1'b0, p_none);
        // Mailbox 1 untouched by mailbox 0
        add_row(32'h0080_0004, 1'b0, 32'h0, U_NONE, CFG_DEF, 32'h0, 1'b0, p_none);
        add_row(32'h0080_0044, 1'b1, 32'h5555_AAAA, U_NONE, CFG_DEF, 32'h0, 1'b1, p_none);
        add_row(32'h0080_0000, 1'b0, 32'h0, U_NONE, CFG_DEF, 32'h0, 1'b0, p_none);
        add_row(32'h0080_0008, 1'b1, 32'h0, U_NONE, CFG_DEF, 32'h0, 1'b0, p_none);
        add_row(32'h0040_0004, 1'b0, 32'h0, U_NONE, CFG_DEF, 32'h1, 1'b0, p_none);
        add_row(32'h0040_0008, 1'b1, 32'h0, U_NONE, CFG_DEF, 32'h0, 1'b0, p_none);
        add_row(32'h0040_0004, 1'b0, 32'h0, U_NONE, CFG_DEF, 32'h0, 1'b0, p_none);
        add_row(32'h0040_0040, 1'b1, 32'h7777_7777, U_NONE, CFG_DEF, 32'h0, 1'b1, p_none);
        add_row(32'h0040_0040, 1'b0, 32'h0, U_NONE, CFG_DEF, 32'h0BAD_F00D, 1'b0, p_none);
        // SRAM writes by the SRAM config user, reads back
        add_row(32'h00C0_0000, 1'b1, rnd[0], U_SRAM, CFG_DEF, 32'h0, 1'b0, p_sram);
        add_row(32'h00C0_0004, 1'b1, rnd[1], U_SRAM, CFG_DEF, 32'h0, 1'b0, p_sram);
        add_row(32'h00C0_0800, 1'b1, rnd[2], U_SRAM, CFG_DEF, 32'h0, 1'b0, p_sram);
        add_row(32'h00C0_0FFC, 1'b1, rnd[3], U_SRAM, CFG_DEF, 32'h0, 1'b0, p_sram);
        add_row(32'h00C0_0000, 1'b0, 32'h0, U_NONE, CFG_DEF, rnd[0], 1'b0, p_none);
        add_row(32'h00C0_0004, 1'b0, 32'h0, U_NONE, CFG_DEF, rnd[1], 1'b0, p_none);
        add_row(32'h00C0_0800, 1'b0, 32'h0, U_NONE, CFG_DEF, rnd[2], 1'b0, p_none);
        add_row(32'h00C0_0FFC, 1'b0, 32'h0, U_NONE, CFG_DEF, rnd[3], 1'b0, p_none);
        // Unprivileged SRAM write dropped
        add_row(32'h00C0_0004, 1'b1, 32'h0F0F_0F0F, U_NONE, CFG_DEF, 32'h0, 1'b1, p_none);
        add_row(32'h00C0_0004, 1'b0, 32'h0, U_NONE, CFG_DEF, rnd[1], 1'b0, p_none);
        // SoC config strap of all ones makes every user count
        add_row(32'h0000_0004, 1'b0, 32'h0, U_NONE, CFG_ALL, 32'hA5A5_1234, 1'b0, p_soc);
        add_row(32'h0000_0004, 1'b0, 32'h0, U_ZERO, CFG_ALL, 32'hA5A5_1234, 1'b0, p_soc);
        add_row(32'h0000_0004, 1'b0, 32'h0, U_LSU, CFG_ALL, 32'hA5A5_1234, 1'b0, p_lsu_soc);
        add_row(32'h0000_0008, 1'b1, 32'h7777_0000, U_NONE, CFG_ALL, 32'h0, 1'b0, p_soc);
        add_row(32'h0000_0008, 1'b0, 32'h0, U_NONE, CFG_ALL, 32'h7777_0000, 1'b0, p_soc);
        // Strap of all zeros disables SoC config even for user 0
        add_row(32'h0000_0008, 1'b0, 32'h0, U_ZERO, 32'h0, 32'h7777_0000, 1'b0, p_none);
        add_row(32'h0000_0008, 1'b1, 32'h3333_3333, U_ZERO, 32'h0, 32'h0, 1'b1, p_none);
        add_row(32'h0000_0008, 1'b0, 32'h0, U_SOC, 32'h0, 32'h7777_0000, 1'b0, p_none);
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        rst                    = 1'b1;
        soc_dv                 = 1'b0;
        soc_req                = '0;
        strap.mcu_lsu_user     = U_LSU;
        strap.mcu_ifu_user     = U_IFU;
        strap.sram_config_user = U_SRAM;
        strap.soc_config_user  = CFG_DEF;

        void'($urandom(SEED));
        foreach (rnd[i]) begin
            rnd[i] = $urandom();
        end
        p_none    = priv_flags(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        p_lsu     = priv_flags(1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
        p_ifu     = priv_flags(1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
        p_soc     = priv_flags(1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
        p_sram    = priv_flags(1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
        p_lsu_soc = priv_flags(1'b1, 1'b0, 1'b1, 1'b1, 1'b0);
        build_table();

        // Reset for 3 cycles
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < rows.size(); i++) begin
            run_row(i, rows[i]);
        end

        @(negedge clk);
        soc_dv = 1'b0;
        @(negedge clk);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* vlog.f */
mci_pkg.sv
mci_axi_sub_decode.sv
mci_reg_block.sv
mci_mbox.sv
mci_sram.sv
mci_sub_top.sv
tb_mci_sub.sv

/* run_sim.sh */
#!/bin/sh
# Build the MCI subordinate fabric testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f vlog.f --top-module tb_mci_sub -o tb_mci_sub \
    && ./obj_dir/tb_mci_sub \
    || exit 1
